/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_l1_d_cache
FILELIST := tb.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_l1_d_cache.sv */
`timescale 1ns/1ns

module tb_l1_d_cache;

    localparam logic [1:0] op_rd = 2'd0;
    localparam logic [1:0] op_wr = 2'd1;
    localparam logic [1:0] op_fl = 2'd2;

    localparam int sets = 2 ** l1_cache_pkg::index_w;
    localparam int max_wait = 100;
    localparam int n_dir = 20;
    localparam int n_rand = 400;

    typedef struct packed {
        logic [1:0] op;
        l1_cache_pkg::data_t addr;
        l1_cache_pkg::data_t wdata;
        logic hit;
    } entry_t;

    // set 3: A tag 1, B tag 2, C tag 3, D tag 4
    localparam entry_t stim [n_dir] = '{
        '{op_rd, 32'h0000_08c4, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_08c4, 32'h0000_0000, 1'b1},
        '{op_wr, 32'h0000_08c8, 32'hdead_beef, 1'b1},
        '{op_rd, 32'h0000_08c8, 32'h0000_0000, 1'b1},
        '{op_rd, 32'h0000_08cc, 32'h0000_0000, 1'b1},
        '{op_rd, 32'h0000_10c0, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_08c0, 32'h0000_0000, 1'b1},
        '{op_rd, 32'h0000_18c0, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_08c0, 32'h0000_0000, 1'b1},
        '{op_rd, 32'h0000_10c0, 32'h0000_0000, 1'b0},
        '{op_wr, 32'h0000_08d0, 32'h1234_5678, 1'b1},
        '{op_rd, 32'h0000_18c0, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_20c0, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_08d0, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_08c8, 32'h0000_0000, 1'b1},
        '{op_wr, 32'h0000_0940, 32'h5555_aaaa, 1'b0},
        '{op_fl, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_0940, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_08c8, 32'h0000_0000, 1'b0},
        '{op_rd, 32'h0000_08c4, 32'h0000_0000, 1'b1}
    };

    logic clk;
    logic nrst;
    logic rd;
    logic wr;
    logic flush;
    l1_cache_pkg::cpu_addr_u addr;
    l1_cache_pkg::data_t wdata;
    l1_cache_pkg::data_t rdata;
    logic done;
    logic hit;
    logic stall;

    // reference model: L2 words that differ from the initial pattern
    l1_cache_pkg::data_t l2_model [int];
    int m_tag [2][sets];
    bit m_valid [2][sets];
    bit m_dirty [2][sets];
    bit m_lru [sets];
    l1_cache_pkg::data_t m_line [2][sets][l1_cache_pkg::words_per_line];

    l1_cache_pkg::data_t exp_data;
    logic exp_hit;
    logic [1:0] r_op;
    l1_cache_pkg::data_t r_addr;
    l1_cache_pkg::data_t r_wdata;

    l1_d_cache_top #(
        .l2_latency (4),
        .l2_lines   (256)
    ) DUT (
        .clk   (clk),
        .nrst  (nrst),
        .rd    (rd),
        .wr    (wr),
        .flush (flush),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .hit   (hit),
        .stall (stall)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_data(input string name, input l1_cache_pkg::data_t exp,
                              input l1_cache_pkg::data_t act);
        if (act !== exp)
        begin
            $display("Error: time %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Regression failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Error: time %0t %s expected %b actual %b", $time, name, exp, act);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic l1_cache_pkg::data_t make_addr(input int tg, input int idx, input int w);
        l1_cache_pkg::cpu_addr_u u;
        u.flat = '0;
        u.f.tag = 21'(tg);
        u.f.index = 5'(idx);
        u.f.word = 4'(w);
        return u.flat;
    endfunction

    // byte address with the upper half inverted, unless written back since
    function automatic l1_cache_pkg::data_t l2_word(input int wa);
        if (l2_model.exists(wa))
            return l2_model[wa];
        return 32'(wa * 4) ^ 32'hffff_0000;
    endfunction

    task automatic model_flush();
        for (int s = 0; s < sets; s++)
        begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_dirty[0][s] = 1'b0;
            m_dirty[1][s] = 1'b0;
            m_lru[s] = 1'b0;
        end
    endtask

    task automatic model_access(input logic [1:0] op, input l1_cache_pkg::data_t a,
                                input l1_cache_pkg::data_t wd,
                                output l1_cache_pkg::data_t exp_d, output logic exp_h);
        l1_cache_pkg::cpu_addr_u ua;
        int idx;
        int tg;
        int ws;
        int base;
        bit w;
        ua.flat = a;
        idx = int'(ua.f.index);
        tg = int'(ua.f.tag);
        ws = int'(ua.f.word);
        exp_h = 1'b1;
        if (m_valid[0][idx] && m_tag[0][idx] == tg)
            w = 1'b0;
        else if (m_valid[1][idx] && m_tag[1][idx] == tg)
            w = 1'b1;
        else
        begin
            exp_h = 1'b0;
            if (!m_valid[0][idx])
                w = 1'b0;
            else if (!m_valid[1][idx])
                w = 1'b1;
            else
                w = m_lru[idx];
            // dirty victim goes back to L2 first
            if (m_valid[w][idx] && m_dirty[w][idx])
            begin
                base = (m_tag[w][idx] * sets + idx) * l1_cache_pkg::words_per_line;
                for (int k = 0; k < l1_cache_pkg::words_per_line; k++)
                    l2_model[base + k] = m_line[w][idx][k];
            end
            base = (tg * sets + idx) * l1_cache_pkg::words_per_line;
            for (int k = 0; k < l1_cache_pkg::words_per_line; k++)
                m_line[w][idx][k] = l2_word(base + k);
            m_valid[w][idx] = 1'b1;
            m_dirty[w][idx] = 1'b0;
            m_tag[w][idx] = tg;
        end
        if (op == op_wr)
        begin
            m_line[w][idx][ws] = wd;
            m_dirty[w][idx] = 1'b1;
        end
        exp_d = m_line[w][idx][ws];
        m_lru[idx] = ~w;
    endtask

    task automatic do_flush();
        @(negedge clk);
        check_flag("stall", 1'b0, stall);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic run_request(input logic [1:0] op, input l1_cache_pkg::data_t a,
                               input l1_cache_pkg::data_t wd, input logic exp_h,
                               input l1_cache_pkg::data_t exp_d);
        int cycles;
        cycles = 0;
        // nothing pending, so stall must be low
        @(negedge clk);
        check_flag("stall", 1'b0, stall);
        @(posedge clk);
        rd <= (op == op_rd);
        wr <= (op == op_wr);
        addr.flat <= a;
        wdata <= wd;
        @(negedge clk);
        while (!done)
        begin
            cycles++;
            if (cycles > max_wait)
            begin
                $display("Timeout: no done within %0d cycles for address %h", max_wait, a);
                $display("Regression failed");
                $fatal(1, "request timed out");
            end
            @(negedge clk);
        end
        check_flag("stall", 1'b1, stall);
        check_flag("hit", exp_h, hit);
        if (op == op_rd)
            check_data("rdata", exp_d, rdata);
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
    endtask

    initial
    begin
        nrst = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        flush = 1'b0;
        addr = '0;
        wdata = '0;
        void'($urandom(85728));
        model_flush();
        repeat (8) @(posedge clk);
        nrst <= 1'b1;

        for (int i = 0; i < n_dir; i++)
        begin
            if (stim[i].op == op_fl)
            begin
                model_flush();
                do_flush();
            end
            else
            begin
                model_access(stim[i].op, stim[i].addr, stim[i].wdata, exp_data, exp_hit);
                run_request(stim[i].op, stim[i].addr, stim[i].wdata, stim[i].hit, exp_data);
            end
        end

        // four sets, eight tags, so plenty of conflict misses
        for (int n = 0; n < n_rand; n++)
        begin
            r_op = ($urandom % 2 == 0) ? op_rd : op_wr;
            r_addr = make_addr(int'($urandom % 8), int'($urandom % 4), int'($urandom % 16));
            r_wdata = $urandom;
            model_access(r_op, r_addr, r_wdata, exp_data, exp_hit);
            run_request(r_op, r_addr, r_wdata, exp_hit, exp_data);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* tb.f */
verilog/l1_cache_pkg.sv
verilog/l1_d_controller.sv
verilog/l1_d_data_array.sv
verilog/l2_backing_store.sv
verilog/l1_d_cache_top.sv
sim/tb_l1_d_cache.sv

/* verilog/l1_cache_pkg.sv */
package l1_cache_pkg;

    // address split: tag | set | word | byte
    localparam int tag_w = 21;
    localparam int index_w = 5;
    localparam int word_w = 4;
    localparam int byte_w = 2;

    localparam int words_per_line = 16;

    typedef logic [31:0] data_t;

    // word 0 sits in the low 32 bits
    typedef data_t [words_per_line-1:0] line_t;

    // line address towards L2, tag above index
    typedef logic [tag_w+index_w-1:0] line_addr_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [index_w-1:0] index;
        logic [word_w-1:0] word;
        logic [byte_w-1:0] offset;
    } cpu_addr_t;

    // cpu address, seen flat or split into fields
    typedef union packed {
        logic [31:0] flat;
        cpu_addr_t f;
    } cpu_addr_u;

endpackage

/* verilog/l1_d_cache_top.sv */
`timescale 1ns/1ns

module l1_d_cache_top #(
    parameter int l2_latency = 4,
    parameter int l2_lines = 256
) (
    input  logic clk,
    input  logic nrst,
    input  logic rd,
    input  logic wr,
    input  logic flush,
    input  l1_cache_pkg::cpu_addr_u addr,
    input  l1_cache_pkg::data_t wdata,
    output l1_cache_pkg::data_t rdata,
    output logic done,
    output logic hit,
    output logic stall
);

    logic store;
    logic fill;
    logic way;
    logic l2_rd;
    logic l2_wr;
    logic l2_ready;
    l1_cache_pkg::line_addr_t l2_addr;
    l1_cache_pkg::line_t victim_line;
    l1_cache_pkg::line_t fill_line;

    l1_d_controller u_ctrl (
        .clk      (clk),
        .nrst     (nrst),
        .rd       (rd),
        .wr       (wr),
        .flush    (flush),
        .addr     (addr),
        .l2_ready (l2_ready),
        .stall    (stall),
        .done     (done),
        .hit      (hit),
        .store    (store),
        .fill     (fill),
        .l2_rd    (l2_rd),
        .l2_wr    (l2_wr),
        .way      (way),
        .l2_addr  (l2_addr)
    );

    // set and word come straight from the cpu address
    l1_d_data_array u_data (
        .clk         (clk),
        .index       (addr.f.index),
        .way         (way),
        .word_sel    (addr.f.word),
        .wdata       (wdata),
        .store       (store),
        .fill        (fill),
        .fill_line   (fill_line),
        .rdata       (rdata),
        .victim_line (victim_line)
    );

    l2_backing_store #(
        .l2_latency (l2_latency),
        .l2_lines   (l2_lines)
    ) u_l2 (
        .clk      (clk),
        .nrst     (nrst),
        .l2_rd    (l2_rd),
        .l2_wr    (l2_wr),
        .l2_addr  (l2_addr),
        .wline    (victim_line),
        .l2_ready (l2_ready),
        .rline    (fill_line)
    );

endmodule

/* verilog/l1_d_controller.sv */
`timescale 1ns/1ns

module l1_d_controller (
    input  logic clk,
    input  logic nrst,
    input  logic rd,
    input  logic wr,
    input  logic flush,
    input  l1_cache_pkg::cpu_addr_u addr,
    input  logic l2_ready,
    output logic stall,
    output logic done,
    output logic hit,
    output logic store,
    output logic fill,
    output logic l2_rd,
    output logic l2_wr,
    output logic way,
    output l1_cache_pkg::line_addr_t l2_addr
);

    localparam int sets = 2 ** l1_cache_pkg::index_w;

    localparam logic [1:0] s_idle = 2'b00;
    localparam logic [1:0] s_compare = 2'b01;
    localparam logic [1:0] s_write_back = 2'b10;
    localparam logic [1:0] s_allocate = 2'b11;

    logic [1:0] state;
    logic [1:0] next_state;

    logic [l1_cache_pkg::tag_w-1:0] tags [2][sets];
    logic [1:0][sets-1:0] valid;
    logic [1:0][sets-1:0] dirty;
    // lru bit names the way to replace next
    logic [sets-1:0] lru;

    logic [l1_cache_pkg::index_w-1:0] idx;
    logic [l1_cache_pkg::tag_w-1:0] req_tag;
    logic [1:0] way_hit;
    logic any_hit;
    logic sel_way;
    logic victim_dirty;
    logic way_q;
    // set once L2 was touched for the current access
    logic used_l2;

    assign idx = addr.f.index;
    assign req_tag = addr.f.tag;

    assign way_hit[0] = valid[0][idx] && (tags[0][idx] == req_tag);
    assign way_hit[1] = valid[1][idx] && (tags[1][idx] == req_tag);
    assign any_hit = |way_hit;

    // matching way, else first free way, else lru
    always_comb
    begin
        if (way_hit[0])
            sel_way = 1'b0;
        else if (way_hit[1])
            sel_way = 1'b1;
        else if (!valid[0][idx])
            sel_way = 1'b0;
        else if (!valid[1][idx])
            sel_way = 1'b1;
        else
            sel_way = lru[idx];
    end

    assign victim_dirty = valid[sel_way][idx] && dirty[sel_way][idx];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= s_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            s_idle:
                if (rd || wr)
                    next_state = s_compare;
            s_compare:
                if (any_hit)
                    next_state = s_idle;
                else if (victim_dirty)
                    next_state = s_write_back;
                else
                    next_state = s_allocate;
            s_write_back:
                if (l2_ready)
                    next_state = s_allocate;
            s_allocate:
                // refilled line is picked up as a hit by compare
                if (l2_ready)
                    next_state = s_compare;
            default:
                next_state = s_idle;
        endcase
    end

    assign stall = (state != s_idle);
    assign done = (state == s_compare) && any_hit;
    assign hit = done && !used_l2;
    assign store = done && wr;
    assign fill = (state == s_allocate) && l2_ready;
    assign way = (state == s_compare) ? sel_way : way_q;

    // victim line during write-back, requested line otherwise
    assign l2_addr = (state == s_write_back) ? {tags[way_q][idx], idx} : {req_tag, idx};

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            way_q <= 1'b0;
            used_l2 <= 1'b0;
        end
        else if (state == s_compare)
        begin
            if (any_hit)
            begin
                used_l2 <= 1'b0;
            end
            else
            begin
                way_q <= sel_way;
                used_l2 <= 1'b1;
            end
        end
    end

    // one-cycle strobes on entry to write-back or allocate
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            l2_rd <= 1'b0;
            l2_wr <= 1'b0;
        end
        else
        begin
            l2_wr <= (state == s_compare) && !any_hit && victim_dirty;
            l2_rd <= ((state == s_compare) && !any_hit && !victim_dirty)
                     || ((state == s_write_back) && l2_ready);
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill)
            tags[way_q][idx] <= req_tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
            lru <= '0;
        end
        else if ((state == s_idle) && flush)
        begin
            // dirty data is dropped, not written back
            valid <= '0;
            dirty <= '0;
            lru <= '0;
        end
        else
        begin
            if (fill)
            begin
                valid[way_q][idx] <= 1'b1;
                dirty[way_q][idx] <= 1'b0;
            end
            if (store)
                dirty[sel_way][idx] <= 1'b1;
            if (done)
                lru[idx] <= ~sel_way;
        end
    end

    assert property (@(posedge clk) disable iff (!nrst) !(l2_rd && l2_wr))
        else $error("l2_rd and l2_wr high together");

    // refilled line must not already sit in the set
    assert property (@(posedge clk) disable iff (!nrst) fill |-> !any_hit)
        else $error("fill of a line already present");

    assert property (@(posedge clk) disable iff (!nrst) done |-> (rd || wr))
        else $error("done without a pending request");

endmodule

/* verilog/l1_d_data_array.sv */
`timescale 1ns/1ns

module l1_d_data_array (
    input  logic clk,
    input  logic [l1_cache_pkg::index_w-1:0] index,
    input  logic way,
    input  logic [l1_cache_pkg::word_w-1:0] word_sel,
    input  l1_cache_pkg::data_t wdata,
    input  logic store,
    input  logic fill,
    input  l1_cache_pkg::line_t fill_line,
    output l1_cache_pkg::data_t rdata,
    output l1_cache_pkg::line_t victim_line
);

    localparam int sets = 2 ** l1_cache_pkg::index_w;

    // one line per set and way
    l1_cache_pkg::line_t lines [2][sets];

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            lines[way][index] <= fill_line;
        end
        else if (store)
        begin
            // single word update on a write hit
            lines[way][index][word_sel] <= wdata;
        end
    end

    // addressed line doubles as write-back source
    assign victim_line = lines[way][index];
    assign rdata = victim_line[word_sel];

    // controller never fills and stores in the same cycle
    assert property (@(posedge clk) !(store && fill))
        else $error("store and fill high together");

endmodule

/* verilog/l2_backing_store.sv */
`timescale 1ns/1ns

module l2_backing_store #(
    parameter int l2_latency = 4,
    parameter int l2_lines = 256
) (
    input  logic clk,
    input  logic nrst,
    input  logic l2_rd,
    input  logic l2_wr,
    input  l1_cache_pkg::line_addr_t l2_addr,
    input  l1_cache_pkg::line_t wline,
    output logic l2_ready,
    output l1_cache_pkg::line_t rline
);

    localparam int aw = $clog2(l2_lines);
    localparam int cw = $clog2(l2_latency + 1);
    localparam int line_bytes = l1_cache_pkg::words_per_line * 4;

    l1_cache_pkg::line_t mem [l2_lines];

    logic [aw-1:0] slot;
    logic [aw-1:0] slot_q;
    // cycles left until the response, zero when idle
    logic [cw-1:0] cnt;

    // only the low line address bits select a slot
    assign slot = l2_addr[aw-1:0];

    initial
    begin
        assert (l2_latency >= 2)
            else $error("l2_latency below 2");
    end

    // each word starts as its byte address, upper half inverted
    initial
    begin
        for (int i = 0; i < l2_lines; i++)
        begin
            for (int w = 0; w < l1_cache_pkg::words_per_line; w++)
                mem[i][w] = 32'(i * line_bytes + w * 4) ^ 32'hffff_0000;
        end
    end

    always @(posedge clk)
    begin
        if (l2_wr)
            mem[slot] <= wline;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            cnt <= '0;
            l2_ready <= 1'b0;
        end
        else
        begin
            l2_ready <= 1'b0;
            if (l2_rd || l2_wr)
            begin
                cnt <= cw'(l2_latency - 1);
            end
            else if (cnt == 1)
            begin
                cnt <= '0;
                l2_ready <= 1'b1;
            end
            else if (cnt != 0)
            begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // read data lands together with l2_ready
    always_ff @(posedge clk)
    begin
        if (l2_rd || l2_wr)
            slot_q <= slot;
        if (cnt == 1)
            rline <= mem[slot_q];
    end

    assert property (@(posedge clk) disable iff (!nrst) (l2_rd || l2_wr) |-> (cnt == 0))
        else $error("L2 strobe while a request is outstanding");

endmodule
